//--- soc_pkg.sv
package soc_pkg;

    // ------------------------------------------------------------
    // Bus types
    // ------------------------------------------------------------
    localparam int WORD_W    = 32;
    localparam int BYTE_W    = 8;
    localparam int WSTRB_W   = WORD_W / BYTE_W;
    localparam int LED_ROW_W = 8;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [WORD_W-1:0]    addr_t;
    typedef logic [WSTRB_W-1:0]   wstrb_t;
    typedef logic [LED_ROW_W-1:0] led_row_t;

    // Byte offset bits below the word index
    localparam int WORD_LSB = 2;

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------
    // Direction register, 1 means the pin drives
    localparam addr_t GPIO_DIR_ADDR    = 32'h1000_0000;
    localparam addr_t GPIO_OUTPUT_ADDR = 32'h1000_0004;
    // Read-only, synchronized pin levels
    localparam addr_t GPIO_INPUT_ADDR  = 32'h1000_0008;

    localparam addr_t LED_FB_ADDR      = 32'h1000_0010;

    // Scratch RAM, size set by the top level
    localparam addr_t RAM_BASE_ADDR    = 32'h2000_0000;

    // ------------------------------------------------------------
    // LED matrix geometry
    // ------------------------------------------------------------
    localparam int LED_COLS = 4;

endpackage

//--- iomem_fabric.sv
`timescale 1ns/10ps

module iomem_fabric #(
    parameter int RAM_WORDS = 256
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                iomem_valid,
    input  soc_pkg::addr_t      iomem_addr,
    input  logic                ram_ready,
    input  logic                gpio_ready,
    input  logic                led_ready,
    input  soc_pkg::word_t      ram_rdata,
    input  soc_pkg::word_t      gpio_rdata,
    input  soc_pkg::word_t      led_rdata,
    output logic                ram_sel,
    output logic                gpio_sel,
    output logic                led_sel,
    output logic                iomem_ready,
    output soc_pkg::word_t      iomem_rdata
);

    // First byte address past the RAM
    localparam soc_pkg::addr_t RAM_END_ADDR =
        soc_pkg::RAM_BASE_ADDR + soc_pkg::addr_t'(RAM_WORDS * 4);

    logic ram_hit;
    logic gpio_hit;
    logic led_hit;

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------
    assign ram_hit  = (iomem_addr >= soc_pkg::RAM_BASE_ADDR) &&
                      (iomem_addr < RAM_END_ADDR);
    assign gpio_hit = (iomem_addr == soc_pkg::GPIO_DIR_ADDR)    ||
                      (iomem_addr == soc_pkg::GPIO_OUTPUT_ADDR) ||
                      (iomem_addr == soc_pkg::GPIO_INPUT_ADDR);
    assign led_hit  = (iomem_addr == soc_pkg::LED_FB_ADDR);

    // Selects drop while ready is up so a held request is served once
    assign ram_sel  = iomem_valid && ram_hit  && !iomem_ready;
    assign gpio_sel = iomem_valid && gpio_hit && !iomem_ready;
    assign led_sel  = iomem_valid && led_hit  && !iomem_ready;

    // ------------------------------------------------------------
    // Ready merge and read data mux
    // ------------------------------------------------------------
    assign iomem_ready = ram_ready | gpio_ready | led_ready;

    always_comb begin
        if (ram_ready) begin
            iomem_rdata = ram_rdata;
        end else if (gpio_ready) begin
            iomem_rdata = gpio_rdata;
        end else if (led_ready) begin
            iomem_rdata = led_rdata;
        end else begin
            iomem_rdata = '0;
        end
    end

    // Targets answer a decoded select only, so their readies never overlap
    a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ram_ready, gpio_ready, led_ready}))
        else $error("More than one target ready in the same cycle");

endmodule

//--- scratch_ram.sv
`timescale 1ns/10ps

module scratch_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sel,
    input  soc_pkg::addr_t      iomem_addr,
    input  soc_pkg::wstrb_t     iomem_wstrb,
    input  soc_pkg::word_t      iomem_wdata,
    output logic                ready,
    output soc_pkg::word_t      rdata
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
    localparam soc_pkg::addr_t RAM_END_ADDR =
        soc_pkg::RAM_BASE_ADDR + soc_pkg::addr_t'(RAM_WORDS * 4);

    soc_pkg::word_t   mem [RAM_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = iomem_addr[soc_pkg::WORD_LSB +: IDX_W];

    // One-cycle answer to every select
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= sel;
        end
    end

    // Read returns the word as it was before this access
    always_ff @(posedge clk) begin
        if (sel) begin
            rdata <= mem[idx];
            for (int b = 0; b < soc_pkg::WSTRB_W; b++) begin
                if (iomem_wstrb[b]) begin
                    mem[idx][soc_pkg::BYTE_W*b +: soc_pkg::BYTE_W] <=
                        iomem_wdata[soc_pkg::BYTE_W*b +: soc_pkg::BYTE_W];
                end
            end
        end
    end

    // The fabric decode must keep the select inside the RAM window
    a_sel_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        sel |-> (iomem_addr >= soc_pkg::RAM_BASE_ADDR) && (iomem_addr < RAM_END_ADDR))
        else $error("RAM selected outside its address range");

endmodule

//--- gpio_ctrl.sv
`timescale 1ns/10ps

module gpio_ctrl #(
    parameter int GPIO_NR = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sel,
    input  soc_pkg::addr_t      iomem_addr,
    input  soc_pkg::wstrb_t     iomem_wstrb,
    input  soc_pkg::word_t      iomem_wdata,
    input  logic [GPIO_NR-1:0]  gpio_in,
    output logic                ready,
    output soc_pkg::word_t      rdata,
    output logic [GPIO_NR-1:0]  gpio_out,
    output logic [GPIO_NR-1:0]  gpio_oe
);

    logic [GPIO_NR-1:0] dir_q;
    logic [GPIO_NR-1:0] out_q;
    logic [GPIO_NR-1:0] in_meta;
    logic [GPIO_NR-1:0] in_sync;

    // ------------------------------------------------------------
    // Control registers and input synchronizer
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready   <= 1'b0;
            dir_q   <= '0;
            out_q   <= '0;
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            ready   <= sel;
            in_meta <= gpio_in;
            in_sync <= in_meta;
            // Input address is read-only, writes to it fall through
            if (sel && |iomem_wstrb) begin
                if (iomem_addr == soc_pkg::GPIO_DIR_ADDR) begin
                    dir_q <= iomem_wdata[GPIO_NR-1:0];
                end else if (iomem_addr == soc_pkg::GPIO_OUTPUT_ADDR) begin
                    out_q <= iomem_wdata[GPIO_NR-1:0];
                end
            end
        end
    end

    // Read mux, registered with the select
    always_ff @(posedge clk) begin
        if (sel) begin
            if (iomem_addr == soc_pkg::GPIO_DIR_ADDR) begin
                rdata <= soc_pkg::word_t'(dir_q);
            end else if (iomem_addr == soc_pkg::GPIO_OUTPUT_ADDR) begin
                rdata <= soc_pkg::word_t'(out_q);
            end else begin
                rdata <= soc_pkg::word_t'(in_sync);
            end
        end
    end

    assign gpio_out = out_q;
    assign gpio_oe  = dir_q;

endmodule

//--- led_matrix_fb.sv
`timescale 1ns/10ps

module led_matrix_fb #(
    parameter int SCAN_DIV = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          sel,
    input  soc_pkg::wstrb_t               iomem_wstrb,
    input  soc_pkg::word_t                iomem_wdata,
    output logic                          ready,
    output soc_pkg::word_t                rdata,
    output soc_pkg::led_row_t             leds,
    output logic [soc_pkg::LED_COLS-1:0]  lcol
);

    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam int COL_W = $clog2(soc_pkg::LED_COLS);

    soc_pkg::word_t   fb;
    logic [DIV_W-1:0] div_cnt;
    logic [COL_W-1:0] col;

    // ------------------------------------------------------------
    // Bus side
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= 1'b0;
            fb    <= '0;
        end else begin
            ready <= sel;
            if (sel && |iomem_wstrb) begin
                fb <= iomem_wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            rdata <= fb;
        end
    end

    // ------------------------------------------------------------
    // Column scanner
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            col     <= '0;
        end else if (div_cnt == DIV_W'(SCAN_DIV - 1)) begin
            div_cnt <= '0;
            col     <= col + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Column 0 shows the top byte, outputs are active low
    assign lcol = ~(soc_pkg::LED_COLS'(1) << col);
    assign leds = ~fb[soc_pkg::LED_ROW_W*(soc_pkg::LED_COLS-1-col) +: soc_pkg::LED_ROW_W];

    // One column low at a time, moving only when the divider wraps
    a_one_col: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(~lcol) && ($stable(lcol) || ($past(div_cnt) == DIV_W'(SCAN_DIV - 1))))
        else $error("LED column drive not one-hot low or moved off the scan period");

endmodule

//--- soc_io.sv
`timescale 1ns/10ps

module soc_io #(
    parameter int RAM_WORDS = 256,
    parameter int GPIO_NR   = 8,
    parameter int SCAN_DIV  = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          iomem_valid,
    input  soc_pkg::addr_t                iomem_addr,
    input  soc_pkg::wstrb_t               iomem_wstrb,
    input  soc_pkg::word_t                iomem_wdata,
    input  logic [GPIO_NR-1:0]            gpio_in,
    output logic                          iomem_ready,
    output soc_pkg::word_t                iomem_rdata,
    output logic [GPIO_NR-1:0]            gpio_out,
    output logic [GPIO_NR-1:0]            gpio_oe,
    output soc_pkg::led_row_t             leds,
    output logic [soc_pkg::LED_COLS-1:0]  lcol
);

    logic           ram_sel;
    logic           gpio_sel;
    logic           led_sel;
    logic           ram_ready;
    logic           gpio_ready;
    logic           led_ready;
    soc_pkg::word_t ram_rdata;
    soc_pkg::word_t gpio_rdata;
    soc_pkg::word_t led_rdata;

    // ------------------------------------------------------------
    // Decode and merge
    // ------------------------------------------------------------
    iomem_fabric #(.RAM_WORDS(RAM_WORDS)) u_fabric (
        .clk         (clk),
        .rst_n       (rst_n),
        .iomem_valid (iomem_valid),
        .iomem_addr  (iomem_addr),
        .ram_ready   (ram_ready),
        .gpio_ready  (gpio_ready),
        .led_ready   (led_ready),
        .ram_rdata   (ram_rdata),
        .gpio_rdata  (gpio_rdata),
        .led_rdata   (led_rdata),
        .ram_sel     (ram_sel),
        .gpio_sel    (gpio_sel),
        .led_sel     (led_sel),
        .iomem_ready (iomem_ready),
        .iomem_rdata (iomem_rdata)
    );

    // ------------------------------------------------------------
    // Targets
    // ------------------------------------------------------------
    scratch_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .sel         (ram_sel),
        .iomem_addr  (iomem_addr),
        .iomem_wstrb (iomem_wstrb),
        .iomem_wdata (iomem_wdata),
        .ready       (ram_ready),
        .rdata       (ram_rdata)
    );

    gpio_ctrl #(.GPIO_NR(GPIO_NR)) u_gpio (
        .clk         (clk),
        .rst_n       (rst_n),
        .sel         (gpio_sel),
        .iomem_addr  (iomem_addr),
        .iomem_wstrb (iomem_wstrb),
        .iomem_wdata (iomem_wdata),
        .gpio_in     (gpio_in),
        .ready       (gpio_ready),
        .rdata       (gpio_rdata),
        .gpio_out    (gpio_out),
        .gpio_oe     (gpio_oe)
    );

    led_matrix_fb #(.SCAN_DIV(SCAN_DIV)) u_led (
        .clk         (clk),
        .rst_n       (rst_n),
        .sel         (led_sel),
        .iomem_wstrb (iomem_wstrb),
        .iomem_wdata (iomem_wdata),
        .ready       (led_ready),
        .rdata       (led_rdata),
        .leds        (leds),
        .lcol        (lcol)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held low over the first rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- tb_soc_io.sv
`timescale 1ns/10ps

module tb_soc_io;

    typedef soc_pkg::word_t word_t;
    typedef soc_pkg::addr_t addr_t;

    localparam int RAM_WORDS     = 256;
    localparam int SCAN_DIV      = 16;
    localparam int READY_TIMEOUT = 8;
    localparam int RESET_TIMEOUT = 10;

    typedef struct {
        string           name;
        addr_t           addr;
        soc_pkg::wstrb_t wstrb;
        word_t           wdata;
        logic [7:0]      gin;
        word_t           exp_rdata;
        bit              chk_rdata;
        bit              exp_ready;
        logic [7:0]      exp_oe;
        logic [7:0]      exp_out;
    } entry_t;

    logic              clk;
    logic              rst_n;
    logic              iomem_valid;
    addr_t             iomem_addr;
    soc_pkg::wstrb_t   iomem_wstrb;
    word_t             iomem_wdata;
    logic [7:0]        gpio_in;
    logic              iomem_ready;
    word_t             iomem_rdata;
    logic [7:0]        gpio_out;
    logic [7:0]        gpio_oe;
    soc_pkg::led_row_t leds;
    logic [3:0]        lcol;

    entry_t stim_q[$];

    // Reference model of the target contents
    word_t      ram_m [int];
    logic [7:0] dir_m;
    logic [7:0] out_m;
    word_t      fb_m;

    tb_clock_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    soc_io UUT (
        .clk(clk), .rst_n(rst_n),
        .iomem_valid(iomem_valid), .iomem_addr(iomem_addr),
        .iomem_wstrb(iomem_wstrb), .iomem_wdata(iomem_wdata),
        .gpio_in(gpio_in), .iomem_ready(iomem_ready), .iomem_rdata(iomem_rdata),
        .gpio_out(gpio_out), .gpio_oe(gpio_oe), .leds(leds), .lcol(lcol)
    );

    task automatic fail_run(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, soc_pkg::wstrb_t strb);
        word_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];
        end
        return w;
    endfunction

    function automatic addr_t ram_addr(int idx);
        return soc_pkg::RAM_BASE_ADDR + addr_t'(idx * 4);
    endfunction

    // Works out the expected answer of one access and queues it
    task automatic add_entry(string name, addr_t addr, soc_pkg::wstrb_t strb, word_t wdata,
                             logic [7:0] gin);
        entry_t e;
        int     idx;
        e = '{name, addr, strb, wdata, gin, 32'h0, 1'b1, 1'b1, 8'h0, 8'h0};
        if (addr >= soc_pkg::RAM_BASE_ADDR &&
            addr < soc_pkg::RAM_BASE_ADDR + addr_t'(RAM_WORDS * 4)) begin
            idx = int'((addr - soc_pkg::RAM_BASE_ADDR) >> 2);
            if (ram_m.exists(idx)) begin
                e.exp_rdata = ram_m[idx];
                ram_m[idx] = merge_bytes(ram_m[idx], wdata, strb);
            end else begin
                // Word never written, its old contents are unknown
                e.chk_rdata = 1'b0;
                if (strb == 4'hF) ram_m[idx] = wdata;
            end
        end else if (addr == soc_pkg::GPIO_DIR_ADDR) begin
            e.exp_rdata = word_t'(dir_m);
            if (strb != 4'h0) dir_m = wdata[7:0];
        end else if (addr == soc_pkg::GPIO_OUTPUT_ADDR) begin
            e.exp_rdata = word_t'(out_m);
            if (strb != 4'h0) out_m = wdata[7:0];
        end else if (addr == soc_pkg::GPIO_INPUT_ADDR) begin
            e.exp_rdata = word_t'(gin);
        end else if (addr == soc_pkg::LED_FB_ADDR) begin
            e.exp_rdata = fb_m;
            if (strb != 4'h0) fb_m = wdata;
        end else begin
            e.chk_rdata = 1'b0;
            e.exp_ready = 1'b0;
        end
        e.exp_oe  = dir_m;
        e.exp_out = out_m;
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        logic [7:0] g;
        dir_m = 8'h0;
        out_m = 8'h0;
        fb_m  = 32'h0;
        add_entry("ram_wr_0", ram_addr(0), 4'hF, $urandom(), 8'h00);
        add_entry("ram_wr_1", ram_addr(1), 4'hF, $urandom(), 8'h00);
        add_entry("ram_wr_37", ram_addr(37), 4'hF, $urandom(), 8'h00);
        add_entry("ram_wr_255", ram_addr(255), 4'hF, $urandom(), 8'h00);
        // Single bytes and a half word over known words
        add_entry("ram_b0_1", ram_addr(1), 4'b0001, $urandom(), 8'h00);
        add_entry("ram_b2_37", ram_addr(37), 4'b0100, $urandom(), 8'h00);
        add_entry("ram_b3_255", ram_addr(255), 4'b1000, $urandom(), 8'h00);
        add_entry("ram_h0_0", ram_addr(0), 4'b0011, $urandom(), 8'h00);
        add_entry("ram_rd_0", ram_addr(0), 4'h0, 32'h0, 8'h00);
        add_entry("ram_rd_1", ram_addr(1), 4'h0, 32'h0, 8'h00);
        add_entry("ram_rd_37", ram_addr(37), 4'h0, 32'h0, 8'h00);
        add_entry("ram_rd_255", ram_addr(255), 4'h0, 32'h0, 8'h00);
        add_entry("gpio_dir_wr", soc_pkg::GPIO_DIR_ADDR, 4'hF, $urandom(), 8'h00);
        add_entry("gpio_dir_rd", soc_pkg::GPIO_DIR_ADDR, 4'h0, 32'h0, 8'h00);
        add_entry("gpio_out_wr", soc_pkg::GPIO_OUTPUT_ADDR, 4'b0001, $urandom(), 8'h00);
        add_entry("gpio_out_rd", soc_pkg::GPIO_OUTPUT_ADDR, 4'h0, 32'h0, 8'h00);
        add_entry("gpio_in_wr", soc_pkg::GPIO_INPUT_ADDR, 4'hF, 32'hFFFF_FFFF, 8'h00);
        add_entry("gpio_dir_rd2", soc_pkg::GPIO_DIR_ADDR, 4'h0, 32'h0, 8'h00);
        add_entry("gpio_out_rd2", soc_pkg::GPIO_OUTPUT_ADDR, 4'h0, 32'h0, 8'h00);
        add_entry("gpio_in_a5", soc_pkg::GPIO_INPUT_ADDR, 4'h0, 32'h0, 8'hA5);
        g = 8'($urandom());
        add_entry("gpio_in_rnd", soc_pkg::GPIO_INPUT_ADDR, 4'h0, 32'h0, g);
        add_entry("led_fb_wr", soc_pkg::LED_FB_ADDR, 4'hF, $urandom(), g);
        add_entry("led_fb_rd", soc_pkg::LED_FB_ADDR, 4'h0, 32'h0, g);
        add_entry("unmapped_rd", 32'h1000_000C, 4'h0, 32'h0, g);
        add_entry("unmapped_wr", 32'h3000_0000, 4'hF, $urandom(), g);
        add_entry("ram_rd_after", ram_addr(37), 4'h0, 32'h0, g);
    endtask

    task automatic apply_entry(entry_t e);
        int cycles;
        bit got;
        @(posedge clk);
        gpio_in <= e.gin;
        // Two edges for the input synchronizer
        repeat (2) @(posedge clk);
        iomem_valid <= 1'b1;
        iomem_addr  <= e.addr;
        iomem_wstrb <= e.wstrb;
        iomem_wdata <= e.wdata;
        @(negedge clk);
        compare({e.name, " early ready"}, 32'h0, word_t'(iomem_ready));
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            got = iomem_ready;
        end
        if (got != e.exp_ready) begin
            if (e.exp_ready) begin
                fail_run($sformatf("No ready for %s within %0d cycles", e.name, READY_TIMEOUT));
            end else begin
                fail_run($sformatf("Unmapped access %s got a ready", e.name));
            end
        end
        if (got) begin
            compare({e.name, " latency"}, 32'd1, word_t'(cycles));
            if (e.chk_rdata) compare({e.name, " rdata"}, e.exp_rdata, iomem_rdata);
        end else begin
            $display("%s: no ready within %0d cycles, as expected", e.name, READY_TIMEOUT);
        end
        compare({e.name, " gpio_oe"}, word_t'(e.exp_oe), word_t'(gpio_oe));
        compare({e.name, " gpio_out"}, word_t'(e.exp_out), word_t'(gpio_out));
        @(posedge clk);
        iomem_valid <= 1'b0;
        iomem_wstrb <= 4'h0;
        // Ready is a single-cycle pulse
        @(negedge clk);
        compare({e.name, " ready pulse"}, 32'h0, word_t'(iomem_ready));
    endtask

    task automatic check_led_scan(word_t fb);
        logic [3:0]        seen;
        soc_pkg::led_row_t exp_row;
        seen = 4'h0;
        for (int c = 0; c < 5 * SCAN_DIV; c++) begin
            @(negedge clk);
            if (!$onehot(~lcol)) fail_run($sformatf("LED column drive %b is not one low", lcol));
            for (int k = 0; k < 4; k++) begin
                if (!lcol[k]) begin
                    exp_row = ~fb[31 - 8*k -: 8];
                    compare($sformatf("led_col_%0d", k), word_t'(exp_row), word_t'(leds));
                    seen[k] = 1'b1;
                end
            end
        end
        if (seen != 4'hF) fail_run($sformatf("LED scan visited only columns %b", seen));
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int n;
        iomem_valid <= 1'b0;
        iomem_addr  <= 32'h0;
        iomem_wstrb <= 4'h0;
        iomem_wdata <= 32'h0;
        gpio_in     <= 8'h0;
        void'($urandom(32'ha084_7a0f));
        n = 0;
        while (rst_n !== 1'b1) begin
            if (n >= RESET_TIMEOUT) fail_run("Reset was never released");
            @(posedge clk);
            n++;
        end
        @(negedge clk);
        compare("reset ready", 32'h0, word_t'(iomem_ready));
        compare("reset gpio_oe", 32'h0, word_t'(gpio_oe));
        compare("reset lcol", 32'hE, word_t'(lcol));
        compare("reset leds", 32'hFF, word_t'(leds));
        build_table();
        foreach (stim_q[i]) apply_entry(stim_q[i]);
        check_led_scan(fb_m);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- list.f
soc_pkg.sv
iomem_fabric.sv
scratch_ram.sv
gpio_ctrl.sv
led_matrix_fb.sv
soc_io.sv
tb_clock_gen.sv
tb_soc_io.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the iomem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
    -f list.f --top-module tb_soc_io -o tb_soc_io

# A failing run exits nonzero, the log decides the result
./obj_dir/tb_soc_io > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
